/* sim.f */
+incdir+include
hdl/otp_scrmbl_pkg.sv
hdl/present_round.sv
hdl/scrmbl_datapath.sv
hdl/scrmbl_ctrl.sv
hdl/otp_scrmbl.sv
tests/scrmbl_ctrl_assertions.sv
tests/tb_otp_scrmbl.sv

/* include/scrmbl_model.svh */
`ifndef SCRMBL_MODEL_SVH
`define SCRMBL_MODEL_SVH

// S-box as a packed nibble table, S(0) in the lowest nibble
function automatic logic [3:0] m_sbox(input logic [3:0] nib);
  logic [63:0] tbl;
  tbl = 64'h2174_8fe3_da09_b65c;
  return tbl[4*nib +: 4];
endfunction

// one round step, key and index advance in place
function automatic void m_round(inout logic [63:0] data,
                                inout logic [127:0] key,
                                inout logic [4:0] idx);
  logic [63:0] s;
  logic [63:0] p;
  s = data ^ key[127:64];
  for (int n = 0; n < 16; n++) begin
    s[4*n +: 4] = m_sbox(s[4*n +: 4]);
  end
  // inverse view of the permutation, output bit j reads input bit 4j mod 63
  for (int j = 0; j < 63; j++) begin
    p[j] = s[(4*j) % 63];
  end
  p[63] = s[63];
  key = {key[66:0], key[127:67]};
  key[127:124] = m_sbox(key[127:124]);
  key[123:120] = m_sbox(key[123:120]);
  key[66:62] = key[66:62] ^ idx;
  idx = idx + 5'd1;
  data = p ^ key[127:64];
endfunction

// full command, index starts at 1
function automatic logic [63:0] m_encrypt(input logic [63:0] data, input logic [127:0] key);
  logic [4:0] idx;
  idx = 5'd1;
  repeat (otp_scrmbl_pkg::NumRounds) begin
    m_round(data, key, idx);
  end
  return data;
endfunction

// digest update from a data_i block and the shadow block
function automatic logic [63:0] m_digest(input logic [63:0] state,
                                         input logic [63:0] hi, input logic [63:0] lo);
  otp_scrmbl_pkg::key_block_u kb;
  kb.blk[1] = hi;
  kb.blk[0] = lo;
  return m_encrypt(state, kb.key) ^ state;
endfunction

// finalization under a set constant, sets past the valid ones use zero
function automatic logic [63:0] m_finalize(input logic [63:0] state, input logic [1:0] sel);
  logic [127:0] k;
  k = (sel < otp_scrmbl_pkg::NumDigestSets) ? otp_scrmbl_pkg::DigestConsts[sel] : '0;
  return m_encrypt(state, k) ^ state;
endfunction

`endif

/* tests/tb_otp_scrmbl.sv */
`timescale 1ns/10ps

module tb_otp_scrmbl;

  logic                                  clk;
  logic                                  rst_n;
  logic [otp_scrmbl_pkg::CmdWidth-1:0]   cmd;
  logic [otp_scrmbl_pkg::SelWidth-1:0]   sel;
  logic [otp_scrmbl_pkg::BlockWidth-1:0] data_in;
  logic                                  valid_in;
  logic                                  ready;
  logic [otp_scrmbl_pkg::BlockWidth-1:0] data_out;
  logic                                  valid_out;

  `include "scrmbl_model.svh"

  int errors;
  int timeouts;

  // reference copies of the digest and shadow registers
  logic [63:0] digest_model;
  logic [63:0] shadow_model;
  // message blocks of one digest sequence
  logic [63:0] msg_hi [4];
  logic [63:0] msg_lo [4];

  otp_scrmbl u_dut (
    .clk_i   (clk),
    .rst_ni  (rst_n),
    .cmd_i   (cmd),
    .sel_i   (sel),
    .data_i  (data_in),
    .valid_i (valid_in),
    .ready_o (ready),
    .data_o  (data_out),
    .valid_o (valid_out)
  );

  // 40 ns period
  initial begin : clock_gen
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////////////////

  // indices past the valid entries select zero
  function automatic logic [127:0] key_for_sel(input logic [1:0] s);
    return (s < otp_scrmbl_pkg::NumKeys) ? otp_scrmbl_pkg::ScrmblKeys[s] : '0;
  endfunction

  function automatic logic [63:0] iv_for_sel(input logic [1:0] s);
    return (s < otp_scrmbl_pkg::NumDigestSets) ? otp_scrmbl_pkg::DigestIvs[s] : '0;
  endfunction

  task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] act);
    assert (act === exp) else begin
      $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
      errors++;
    end
  endtask

  // all sampling and driving happens 2 ns after the edge
  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  task automatic send_cmd(input string name, input logic [2:0] c, input logic [1:0] s,
                          input logic [63:0] d, output bit accepted);
    int n;
    n = 0;
    accepted = 1'b0;
    while (!ready && n < 100) begin
      next_cycle();
      n++;
    end
    if (!ready) begin
      $display("%s: ready_o stayed low for 100 cycles, command not sent", name);
      timeouts++;
    end else begin
      cmd      = c;
      sel      = s;
      data_in  = d;
      valid_in = 1'b1;
      next_cycle();
      valid_in = 1'b0;
      accepted = 1'b1;
    end
  endtask

  // command with a 31-round run and a valid pulse
  task automatic round_cmd(input string name, input logic [2:0] c, input logic [1:0] s,
                           input logic [63:0] d, input logic [63:0] exp,
                           output logic [63:0] got);
    bit accepted;
    int n;
    got = '0;
    send_cmd(name, c, s, d, accepted);
    if (accepted) begin
      // n counts edges after the accepting edge
      n = 0;
      while (!valid_out && n < 100) begin
        check_val({name, " busy ready"}, 64'd0, 64'(ready));
        check_val({name, " gated data"}, 64'd0, data_out);
        next_cycle();
        n++;
      end
      if (!valid_out) begin
        $display("%s: no valid_o pulse within 100 cycles", name);
        timeouts++;
      end else begin
        got = data_out;
        // pulse set by the 31st round edge, so it is sampled high on the 32nd
        check_val({name, " latency"}, 64'(otp_scrmbl_pkg::NumRounds), 64'(n));
        check_val({name, " result"}, exp, data_out);
        check_val({name, " ready at pulse"}, 64'd1, 64'(ready));
        next_cycle();
        // pulse lasts one cycle, output back to zero
        check_val({name, " pulse end"}, 64'd0, 64'(valid_out));
        check_val({name, " data after pulse"}, 64'd0, data_out);
      end
    end
  endtask

  // single-cycle or ignored command, controller stays idle
  task automatic quick_cmd(input string name, input logic [2:0] c, input logic [1:0] s,
                           input logic [63:0] d);
    bit accepted;
    send_cmd(name, c, s, d, accepted);
    if (accepted) begin
      check_val({name, " ready"}, 64'd1, 64'(ready));
      check_val({name, " no pulse"}, 64'd0, 64'(valid_out));
    end
  endtask

  task automatic encrypt_random(input string name);
    logic [1:0]  s;
    logic [63:0] d;
    logic [63:0] got;
    s = 2'($urandom_range(3, 0));
    d = {$urandom(), $urandom()};
    round_cmd(name, otp_scrmbl_pkg::CmdEncrypt, s, d, m_encrypt(d, key_for_sel(s)), got);
  endtask

  // init, nblk absorb steps, finalize; optional encryptions in between
  task automatic digest_sequence(input string name, input bit interleave, input int nblk,
                                 input logic [1:0] iv_sel, input logic [1:0] fin_sel,
                                 output logic [63:0] final_val);
    logic [63:0] got;
    quick_cmd({name, " init"}, otp_scrmbl_pkg::CmdDigestInit, iv_sel, {$urandom(), $urandom()});
    digest_model = iv_for_sel(iv_sel);
    for (int k = 0; k < nblk; k++) begin
      quick_cmd({name, " shadow"}, otp_scrmbl_pkg::CmdLoadShadow, 2'($urandom_range(3, 0)),
                msg_lo[k]);
      shadow_model = msg_lo[k];
      if (interleave) begin
        encrypt_random({name, " mid encrypt"});
      end
      digest_model = m_digest(digest_model, msg_hi[k], shadow_model);
      round_cmd({name, " absorb"}, otp_scrmbl_pkg::CmdDigest, 2'($urandom_range(3, 0)),
                msg_hi[k], digest_model, got);
    end
    if (interleave) begin
      encrypt_random({name, " pre final encrypt"});
    end
    digest_model = m_finalize(digest_model, fin_sel);
    round_cmd({name, " finalize"}, otp_scrmbl_pkg::CmdDigestFinalize, fin_sel,
              {$urandom(), $urandom()}, digest_model, got);
    final_val = got;
  endtask

  ////////////////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////////////////

  initial begin : stimulus
    logic [63:0] plain_final;
    logic [63:0] mixed_final;
    logic [1:0]  iv_sel;
    logic [1:0]  fin_sel;
    int          n;
    void'($urandom(32'h7dda));
    errors   = 0;
    timeouts = 0;
    rst_n    = 1'b0;
    cmd      = '0;
    sel      = '0;
    data_in  = '0;
    valid_in = 1'b0;
    repeat (16) @(posedge clk);
    #2;
    rst_n = 1'b1;

    // reset values
    check_val("reset ready", 64'd1, 64'(ready));
    check_val("reset valid", 64'd0, 64'(valid_out));
    check_val("reset data", 64'd0, data_out);

    // every key index once, then random ones
    for (int s = 0; s < 4; s++) begin
      logic [63:0] d;
      logic [63:0] got;
      d = {$urandom(), $urandom()};
      round_cmd("encrypt sel", otp_scrmbl_pkg::CmdEncrypt, 2'(s), d,
                m_encrypt(d, key_for_sel(2'(s))), got);
    end
    for (int i = 0; i < 12; i++) begin
      encrypt_random("encrypt random");
    end

    // unused codes must not start a run
    for (int c = 5; c < 8; c++) begin
      quick_cmd("ignored code", 3'(c), 2'($urandom_range(3, 0)), {$urandom(), $urandom()});
      n = 0;
      while (n < 40) begin
        check_val("ignored code no pulse", 64'd0, 64'(valid_out));
        check_val("ignored code idle", 64'd1, 64'(ready));
        next_cycle();
        n++;
      end
    end

    // same message twice, plain then with encryptions mixed in
    for (int r = 0; r < 3; r++) begin
      iv_sel  = 2'($urandom_range(3, 0));
      fin_sel = 2'($urandom_range(3, 0));
      for (int k = 0; k < 4; k++) begin
        msg_hi[k] = {$urandom(), $urandom()};
        msg_lo[k] = {$urandom(), $urandom()};
      end
      digest_sequence("digest", 1'b0, 2 + r, iv_sel, fin_sel, plain_final);
      digest_sequence("interleaved digest", 1'b1, 2 + r, iv_sel, fin_sel, mixed_final);
      check_val("interleaved final digest", plain_final, mixed_final);
    end

    $display("closing: %0d check errors, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

/* tests/scrmbl_ctrl_assertions.sv */
`timescale 1ns/10ps

module scrmbl_ctrl_assertions (
  input logic                                clk_i,
  input logic                                rst_ni,
  input logic [otp_scrmbl_pkg::CmdWidth-1:0] cmd_i,
  input logic                                valid_i,
  input logic                                ready_i,
  input logic                                out_valid_i,
  input logic [1:0]                          data_sel_i,
  input logic [1:0]                          key_sel_i,
  input logic                                data_en_i,
  input logic                                key_en_i,
  input logic [otp_scrmbl_pkg::CntWidth-1:0] cnt_i
);

  // commands that start a 31-round run
  logic run_cmd;
  assign run_cmd = (cmd_i == otp_scrmbl_pkg::CmdEncrypt) ||
                   (cmd_i == otp_scrmbl_pkg::CmdDigest) ||
                   (cmd_i == otp_scrmbl_pkg::CmdDigestFinalize);

  // pulse only comes with the return to idle
  a_valid_ready : assert property (@(posedge clk_i) disable iff (!rst_ni)
    out_valid_i |-> ready_i) else $error("valid_o high while controller busy");

  a_busy_after_accept : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (valid_i && ready_i && run_cmd) |=> !ready_i) else $error("ready_o still high after run start");

  a_cnt_range : assert property (@(posedge clk_i) disable iff (!rst_ni)
    cnt_i <= (otp_scrmbl_pkg::NumRounds - 1)) else $error("round counter out of range");

  a_sel_known : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (data_en_i || key_en_i) |-> !$isunknown({data_sel_i, key_sel_i}))
    else $error("mux select unknown while enabled");

endmodule

bind scrmbl_ctrl scrmbl_ctrl_assertions u_ctrl_assertions (
  .clk_i       (clk_i),
  .rst_ni      (rst_ni),
  .cmd_i       (cmd_i),
  .valid_i     (valid_i),
  .ready_i     (ready_o),
  .out_valid_i (valid_o),
  .data_sel_i  (data_sel_o),
  .key_sel_i   (key_sel_o),
  .data_en_i   (data_en_o),
  .key_en_i    (key_en_o),
  .cnt_i       (cnt_q)
);

/* hdl/otp_scrmbl.sv */
`timescale 1ns/10ps

module otp_scrmbl (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  input  logic [otp_scrmbl_pkg::CmdWidth-1:0]   cmd_i,
  input  logic [otp_scrmbl_pkg::SelWidth-1:0]   sel_i,
  input  logic [otp_scrmbl_pkg::BlockWidth-1:0] data_i,
  input  logic                                  valid_i,
  output logic                                  ready_o,
  output logic [otp_scrmbl_pkg::BlockWidth-1:0] data_o,
  output logic                                  valid_o
);

  // controller steering into the datapath
  logic [1:0] data_sel;
  logic [1:0] key_sel;
  logic       data_en;
  logic       key_en;
  logic       shadow_load;
  logic       digest_init;
  logic       digest_en;

  scrmbl_ctrl u_ctrl (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .cmd_i         (cmd_i),
    .valid_i       (valid_i),
    .ready_o       (ready_o),
    .valid_o       (valid_o),
    .data_sel_o    (data_sel),
    .key_sel_o     (key_sel),
    .data_en_o     (data_en),
    .key_en_o      (key_en),
    .shadow_load_o (shadow_load),
    .digest_init_o (digest_init),
    .digest_en_o   (digest_en)
  );

  // output valid pulse also gates data_o
  scrmbl_datapath u_datapath (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .sel_i         (sel_i),
    .data_i        (data_i),
    .valid_i       (valid_o),
    .data_sel_i    (data_sel),
    .key_sel_i     (key_sel),
    .data_en_i     (data_en),
    .key_en_i      (key_en),
    .shadow_load_i (shadow_load),
    .digest_init_i (digest_init),
    .digest_en_i   (digest_en),
    .data_o        (data_o)
  );

endmodule

/* hdl/scrmbl_ctrl.sv */
`timescale 1ns/10ps

module scrmbl_ctrl (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic [otp_scrmbl_pkg::CmdWidth-1:0] cmd_i,
  input  logic                                valid_i,
  output logic                                ready_o,
  output logic                                valid_o,
  output logic [1:0]                          data_sel_o,
  output logic [1:0]                          key_sel_o,
  output logic                                data_en_o,
  output logic                                key_en_o,
  output logic                                shadow_load_o,
  output logic                                digest_init_o,
  output logic                                digest_en_o
);

  logic [1:0]                          state_d, state_q;
  logic [otp_scrmbl_pkg::CntWidth-1:0] cnt_d, cnt_q;
  logic                                valid_d, valid_q;
  logic                                last_round;

  // counter value on the final round edge
  assign last_round = (cnt_q == (otp_scrmbl_pkg::CntWidth)'(otp_scrmbl_pkg::NumRounds - 1));

  //////////////////////////////////////////////////////////////////////
  // state machine
  //////////////////////////////////////////////////////////////////////

  always_comb begin : p_fsm
    state_d       = state_q;
    cnt_d         = '0;
    valid_d       = 1'b0;
    ready_o       = 1'b0;
    data_sel_o    = otp_scrmbl_pkg::DataSelDataIn;
    key_sel_o     = otp_scrmbl_pkg::KeySelDigestInput;
    data_en_o     = 1'b0;
    key_en_o      = 1'b0;
    shadow_load_o = 1'b0;
    digest_init_o = 1'b0;
    digest_en_o   = 1'b0;

    case (state_q)
      // accept and decode, counter stays cleared
      otp_scrmbl_pkg::StIdle: begin
        ready_o = 1'b1;
        if (valid_i) begin
          case (cmd_i)
            otp_scrmbl_pkg::CmdEncrypt: begin
              state_d   = otp_scrmbl_pkg::StEncrypt;
              key_sel_o = otp_scrmbl_pkg::KeySelEncKeyInit;
              data_en_o = 1'b1;
              key_en_o  = 1'b1;
            end
            // single-cycle commands, no valid pulse
            otp_scrmbl_pkg::CmdLoadShadow: shadow_load_o = 1'b1;
            otp_scrmbl_pkg::CmdDigestInit: begin
              digest_init_o = 1'b1;
              digest_en_o   = 1'b1;
            end
            // digest state is the plaintext, message block is the key
            otp_scrmbl_pkg::CmdDigest: begin
              state_d    = otp_scrmbl_pkg::StDigest;
              data_sel_o = otp_scrmbl_pkg::DataSelDigestState;
              data_en_o  = 1'b1;
              key_en_o   = 1'b1;
            end
            otp_scrmbl_pkg::CmdDigestFinalize: begin
              state_d    = otp_scrmbl_pkg::StDigest;
              data_sel_o = otp_scrmbl_pkg::DataSelDigestState;
              key_sel_o  = otp_scrmbl_pkg::KeySelDigestConst;
              data_en_o  = 1'b1;
              key_en_o   = 1'b1;
            end
            default: state_d = otp_scrmbl_pkg::StIdle;
          endcase
        end
      end
      // one round per cycle, both runs share the round path
      otp_scrmbl_pkg::StEncrypt, otp_scrmbl_pkg::StDigest: begin
        data_sel_o = otp_scrmbl_pkg::DataSelEncOut;
        key_sel_o  = otp_scrmbl_pkg::KeySelRoundKey;
        data_en_o  = 1'b1;
        key_en_o   = 1'b1;
        cnt_d      = cnt_q + otp_scrmbl_pkg::CntWidth'(1);
        if (last_round) begin
          state_d = otp_scrmbl_pkg::StIdle;
          valid_d = 1'b1;
          cnt_d   = '0;
          // digest run ends with the feed-forward and a state update
          if (state_q == otp_scrmbl_pkg::StDigest) begin
            data_sel_o  = otp_scrmbl_pkg::DataSelEncOutXor;
            digest_en_o = 1'b1;
          end
        end
      end
      default: state_d = otp_scrmbl_pkg::StIdle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_regs
    if (!rst_ni) begin
      state_q <= otp_scrmbl_pkg::StIdle;
      cnt_q   <= '0;
      valid_q <= 1'b0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
      valid_q <= valid_d;
    end
  end

  assign valid_o = valid_q;

endmodule

/* hdl/scrmbl_datapath.sv */
`timescale 1ns/10ps

module scrmbl_datapath (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  input  logic [otp_scrmbl_pkg::SelWidth-1:0]   sel_i,
  input  logic [otp_scrmbl_pkg::BlockWidth-1:0] data_i,
  input  logic                                  valid_i,
  input  logic [1:0]                            data_sel_i,
  input  logic [1:0]                            key_sel_i,
  input  logic                                  data_en_i,
  input  logic                                  key_en_i,
  input  logic                                  shadow_load_i,
  input  logic                                  digest_init_i,
  input  logic                                  digest_en_i,
  output logic [otp_scrmbl_pkg::BlockWidth-1:0] data_o
);

  //////////////////////////////////////////////////////////////////////
  // working registers and round outputs
  //////////////////////////////////////////////////////////////////////

  otp_scrmbl_pkg::key_block_u key_d, key_q;
  otp_scrmbl_pkg::key_block_u digest_in;

  logic [otp_scrmbl_pkg::IdxWidth-1:0]   idx_d, idx_q;
  logic [otp_scrmbl_pkg::BlockWidth-1:0] data_d, data_q;
  logic [otp_scrmbl_pkg::BlockWidth-1:0] shadow_q;
  logic [otp_scrmbl_pkg::BlockWidth-1:0] digest_d, digest_q;

  logic [otp_scrmbl_pkg::BlockWidth-1:0] round_data;
  logic [otp_scrmbl_pkg::BlockWidth-1:0] round_xor;
  logic [otp_scrmbl_pkg::KeyWidth-1:0]   round_key;
  logic [otp_scrmbl_pkg::IdxWidth-1:0]   round_idx;

  // constant lookups, index 3 reads as zero
  logic [otp_scrmbl_pkg::KeyWidth-1:0]   enc_key;
  logic [otp_scrmbl_pkg::KeyWidth-1:0]   digest_const;
  logic [otp_scrmbl_pkg::BlockWidth-1:0] digest_iv;

  assign enc_key      = otp_scrmbl_pkg::ScrmblKeys[sel_i];
  assign digest_const = otp_scrmbl_pkg::DigestConsts[sel_i];
  assign digest_iv    = otp_scrmbl_pkg::DigestIvs[sel_i];

  // message block: data_i on top, shadow below
  always_comb begin : p_digest_in
    digest_in.blk[1] = data_i;
    digest_in.blk[0] = shadow_q;
  end

  //////////////////////////////////////////////////////////////////////
  // next-state muxes
  //////////////////////////////////////////////////////////////////////

  always_comb begin : p_key_mux
    // every init load restarts the round index at 1
    idx_d = otp_scrmbl_pkg::IdxWidth'(1);
    case (key_sel_i)
      otp_scrmbl_pkg::KeySelRoundKey: begin
        key_d.key = round_key;
        idx_d     = round_idx;
      end
      otp_scrmbl_pkg::KeySelEncKeyInit:  key_d.key = enc_key;
      otp_scrmbl_pkg::KeySelDigestConst: key_d.key = digest_const;
      default:                           key_d.key = digest_in.key;
    endcase
  end

  // Davies-Meyer feed-forward
  assign round_xor = round_data ^ digest_q;

  always_comb begin : p_data_mux
    case (data_sel_i)
      otp_scrmbl_pkg::DataSelEncOut:      data_d = round_data;
      otp_scrmbl_pkg::DataSelDigestState: data_d = digest_q;
      otp_scrmbl_pkg::DataSelEncOutXor:   data_d = round_xor;
      default:                            data_d = data_i;
    endcase
  end

  // digest chain starts from an IV, then absorbs each result
  assign digest_d = digest_init_i ? digest_iv : round_xor;

  present_round u_round (
    .data_i (data_q),
    .key_i  (key_q.key),
    .idx_i  (idx_q),
    .data_o (round_data),
    .key_o  (round_key),
    .idx_o  (round_idx)
  );

  //////////////////////////////////////////////////////////////////////
  // registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_idx_reg
    if (!rst_ni) begin
      idx_q <= '0;
    end else if (key_en_i) begin
      idx_q <= idx_d;
    end
  end

  always_ff @(posedge clk_i) begin : p_state_regs
    if (key_en_i) begin
      key_q <= key_d;
    end
    if (data_en_i) begin
      data_q <= data_d;
    end
    if (shadow_load_i) begin
      shadow_q <= data_i;
    end
    if (digest_en_i) begin
      digest_q <= digest_d;
    end
  end

  // result only visible during the valid pulse
  assign data_o = valid_i ? data_q : '0;

endmodule

/* hdl/present_round.sv */
`timescale 1ns/10ps

module present_round (
  input  logic [otp_scrmbl_pkg::BlockWidth-1:0] data_i,
  input  logic [otp_scrmbl_pkg::KeyWidth-1:0]   key_i,
  input  logic [otp_scrmbl_pkg::IdxWidth-1:0]   idx_i,
  output logic [otp_scrmbl_pkg::BlockWidth-1:0] data_o,
  output logic [otp_scrmbl_pkg::KeyWidth-1:0]   key_o,
  output logic [otp_scrmbl_pkg::IdxWidth-1:0]   idx_o
);

  // 4-bit PRESENT S-box
  function automatic logic [3:0] sbox4(input logic [3:0] nib);
    logic [3:0] res;
    case (nib)
      4'h0: res = 4'hc;
      4'h1: res = 4'h5;
      4'h2: res = 4'h6;
      4'h3: res = 4'hb;
      4'h4: res = 4'h9;
      4'h5: res = 4'h0;
      4'h6: res = 4'ha;
      4'h7: res = 4'hd;
      4'h8: res = 4'h3;
      4'h9: res = 4'he;
      4'ha: res = 4'hf;
      4'hb: res = 4'h8;
      4'hc: res = 4'h4;
      4'hd: res = 4'h7;
      4'he: res = 4'h1;
      default: res = 4'h2;
    endcase
    return res;
  endfunction

  logic [otp_scrmbl_pkg::BlockWidth-1:0] sub_state;
  logic [otp_scrmbl_pkg::BlockWidth-1:0] perm_state;
  logic [otp_scrmbl_pkg::KeyWidth-1:0]   key_rot;

  always_comb begin : p_round
    // add round key from the upper key half, then substitute
    sub_state = data_i ^ key_i[127:64];
    for (int n = 0; n < 16; n++) begin
      sub_state[4*n +: 4] = sbox4(sub_state[4*n +: 4]);
    end
    // bit i moves to 16*i mod 63, msb stays in place
    perm_state[63] = sub_state[63];
    for (int i = 0; i < 63; i++) begin
      perm_state[(16*i) % 63] = sub_state[i];
    end
    // key schedule: rotate left by 61
    key_rot = {key_i[66:0], key_i[127:67]};
    key_o = key_rot;
    // top two nibbles through the S-box
    key_o[127:124] = sbox4(key_rot[127:124]);
    key_o[123:120] = sbox4(key_rot[123:120]);
    // round counter mixed into bits 66..62
    key_o[66:62] = key_rot[66:62] ^ idx_i;
    data_o = perm_state ^ key_o[127:64];
  end

  assign idx_o = idx_i + otp_scrmbl_pkg::IdxWidth'(1);

endmodule

/* hdl/otp_scrmbl_pkg.sv */
package otp_scrmbl_pkg;

  //////////////////////////////////////////////////////////////////////
  // widths and counts
  //////////////////////////////////////////////////////////////////////

  // one cipher block, also the digest width
  localparam int BlockWidth = 64;
  // PRESENT-128 key
  localparam int KeyWidth = 128;
  // round steps per command
  localparam int NumRounds = 31;
  localparam int IdxWidth = 5;
  localparam int CntWidth = 5;
  // sel_i picks a key or a digest set
  localparam int SelWidth = 2;
  localparam int NumKeys = 3;
  localparam int NumDigestSets = 2;
  localparam int CmdWidth = 3;

  //////////////////////////////////////////////////////////////////////
  // encodings
  //////////////////////////////////////////////////////////////////////

  // commands, codes 5 to 7 are ignored
  localparam logic [CmdWidth-1:0] CmdEncrypt = 3'd0;
  localparam logic [CmdWidth-1:0] CmdLoadShadow = 3'd1;
  localparam logic [CmdWidth-1:0] CmdDigestInit = 3'd2;
  localparam logic [CmdWidth-1:0] CmdDigest = 3'd3;
  localparam logic [CmdWidth-1:0] CmdDigestFinalize = 3'd4;

  // data state mux
  localparam logic [1:0] DataSelEncOut = 2'd0;
  localparam logic [1:0] DataSelDigestState = 2'd1;
  localparam logic [1:0] DataSelEncOutXor = 2'd2;
  localparam logic [1:0] DataSelDataIn = 2'd3;

  // key state mux
  localparam logic [1:0] KeySelRoundKey = 2'd0;
  localparam logic [1:0] KeySelEncKeyInit = 2'd1;
  localparam logic [1:0] KeySelDigestConst = 2'd2;
  localparam logic [1:0] KeySelDigestInput = 2'd3;

  // controller states
  localparam logic [1:0] StIdle = 2'd0;
  localparam logic [1:0] StEncrypt = 2'd1;
  localparam logic [1:0] StDigest = 2'd2;

  //////////////////////////////////////////////////////////////////////
  // constant tables
  //////////////////////////////////////////////////////////////////////

  // valid entries only, index 0 in the lowest slot
  localparam logic [NumKeys-1:0][KeyWidth-1:0] KeyValues = {
    128'h9d1f_2a6c_e047_b35a_81c6_4f0e_7b29_d5a3,
    128'h3e8b_c1f4_5a07_926d_e3b8_0c75_1fa9_64d2,
    128'h5c2e_a8f1_0b97_d46e_3a15_c9f8_72e0_b41d
  };
  localparam logic [NumDigestSets-1:0][KeyWidth-1:0] ConstValues = {
    128'hb7e1_5162_8aed_2a6a_bf71_5880_9cf4_f3c7,
    128'h243f_6a88_85a3_08d3_1319_8a2e_0370_7344
  };
  localparam logic [NumDigestSets-1:0][BlockWidth-1:0] IvValues = {
    64'ha409_3822_299f_31d0,
    64'h082e_fa98_ec4e_6c89
  };

  // padded to four entries, unused indices read as zero
  localparam logic [2**SelWidth-1:0][KeyWidth-1:0] ScrmblKeys =
    ((2**SelWidth)*KeyWidth)'(KeyValues);
  localparam logic [2**SelWidth-1:0][KeyWidth-1:0] DigestConsts =
    ((2**SelWidth)*KeyWidth)'(ConstValues);
  localparam logic [2**SelWidth-1:0][BlockWidth-1:0] DigestIvs =
    ((2**SelWidth)*BlockWidth)'(IvValues);

  // digest input is written as two blocks and used as one key
  typedef union packed {
    logic [KeyWidth-1:0]             key;
    logic [1:0][BlockWidth-1:0]      blk;
  } key_block_u;

endpackage
